// File: list.f
+incdir+tests
verilog/icache_pkg.sv
verilog/icache_if.sv
verilog/icache_ctrl.sv
verilog/icache_tag_array.sv
verilog/icache_data_array.sv
verilog/icache_way_select.sv
verilog/icache_top.sv
tests/icache_checker.sv
tests/tb_icache.sv

// File: Makefile
# Verilator build for the instruction cache testbench

TOP = tb_icache

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing -f list.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "\*\*\* PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tests/mem_model.svh
/*
 * Refill memory contents seen by the testbench
 * One 32-bit word per byte address, fixed function of the address
 */

function automatic logic [31:0] mem_word(input logic [31:0] addr);
   return {addr[15:0], addr[31:16]} ^ (addr * 32'h9E37_79B1) ^ 32'hC0DE_0000;
endfunction

// File: tests/tb_icache.sv
/*
 * Instruction cache testbench
 * Clock, reset, LFSR stimulus, refill memory responder, DUT and checker
 */

`timescale 1ns/1ps

module tb_icache;
   `include "mem_model.svh"

   localparam int N_FETCH = 240;
   localparam int LIMIT   = 40 * N_FETCH + 3 * 16 + 20;   // Fetches plus flushes

   logic          clk;
   logic          rst_n;
   logic          fetch_req_i;
   logic [31:0]   fetch_addr_i;
   logic          fetch_gnt_o;
   logic          fetch_rvalid_o;
   logic [31:0]   fetch_rdata_o;
   logic          refill_req_o;
   logic [31:0]   refill_addr_o;
   logic          refill_gnt_i;
   logic          refill_rvalid_i;
   logic [127:0]  refill_rdata_i;
   logic          bypass_i;
   logic          flush_i;
   logic          is_bypassed_o;
   logic          is_flushed_o;

   logic [15:0]   lfsr;
   int            cycles = 0;
   int            fl_before;
   logic [31:0]   xfer_addr;
   int            dly;

   icache_top dut_i
   (
      .clk(clk), .rst_n(rst_n),
      .fetch_req_i(fetch_req_i), .fetch_addr_i(fetch_addr_i), .fetch_gnt_o(fetch_gnt_o),
      .fetch_rvalid_o(fetch_rvalid_o), .fetch_rdata_o(fetch_rdata_o),
      .refill_req_o(refill_req_o), .refill_addr_o(refill_addr_o),
      .refill_gnt_i(refill_gnt_i), .refill_rvalid_i(refill_rvalid_i),
      .refill_rdata_i(refill_rdata_i),
      .bypass_i(bypass_i), .flush_i(flush_i),
      .is_bypassed_o(is_bypassed_o), .is_flushed_o(is_flushed_o)
   );

   icache_checker chk
   (
      .clk(clk), .rst_n(rst_n),
      .fetch_req_i(fetch_req_i), .fetch_addr_i(fetch_addr_i), .fetch_gnt_o(fetch_gnt_o),
      .fetch_rvalid_o(fetch_rvalid_o), .fetch_rdata_o(fetch_rdata_o),
      .refill_req_o(refill_req_o), .refill_addr_o(refill_addr_o),
      .refill_gnt_i(refill_gnt_i), .refill_rvalid_i(refill_rvalid_i),
      .bypass_i(bypass_i), .is_bypassed_o(is_bypassed_o), .is_flushed_o(is_flushed_o)
   );

   // Fibonacci LFSR, taps 16,14,13,11
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         r    = {r[30:0], fb};
      end
      return r;
   endfunction

   // 8 tags over 4 sets, so sets fill up and evict
   function automatic logic [31:0] rand_addr();
      logic [31:0] a;
      a = 32'h0001_0000;
      a[10:8] = rand_bits(3);
      a[5:4]  = rand_bits(2);
      a[3:2]  = rand_bits(2);
      return a;
   endfunction

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles > LIMIT)
      begin
         $display("Timeout after %0d cycles, a handshake never completed", cycles);
         $display("*** FAILED ***");
         $finish;
      end
   end

   ////////////////////
   // Refill responder, lane k holds the word at addr + 4k
   initial
   begin
      forever
      begin
         @(posedge clk);
         if (refill_req_o)
         begin
            dly = rand_bits(2);
            repeat (dly) @(posedge clk);
            #1 refill_gnt_i = 1'b1;
            @(posedge clk);
            xfer_addr = refill_addr_o;
            dly = 1 + rand_bits(2);
            #1 refill_gnt_i = 1'b0;
            repeat (dly - 1) @(posedge clk);
            #1;
            refill_rvalid_i = 1'b1;
            for (int k = 0; k < 4; k++)
               refill_rdata_i[32*k +: 32] = mem_word(xfer_addr + 32'(4 * k));
            @(posedge clk);
            #1 refill_rvalid_i = 1'b0;
         end
      end
   end

   ////////////////////
   // Stimulus tasks, entered 1 ns after an edge
   task automatic do_fetch(input logic [31:0] addr);
      fetch_req_i  = 1'b1;
      fetch_addr_i = addr;
      @(posedge clk);
      while (!fetch_gnt_o)
         @(posedge clk);
      #1 fetch_req_i = 1'b0;
      if (rand_bits(1) == 32'd1)
      begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic wait_idle();
      while (chk.pending() != 0)
         @(posedge clk);
      @(posedge clk);
      #1;
   endtask

   task automatic wait_flushed();
      @(posedge clk);
      while (!is_flushed_o)
         @(posedge clk);
      #1;
   endtask

   task automatic run_random(input int n);
      for (int i = 0; i < n; i++)
         do_fetch(rand_addr());
      wait_idle();
   endtask

   initial
   begin
      lfsr            = 16'd50984;
      rst_n           = 1'b0;
      fetch_req_i     = 1'b0;
      fetch_addr_i    = '0;
      refill_gnt_i    = 1'b0;
      refill_rvalid_i = 1'b0;
      refill_rdata_i  = '0;
      bypass_i        = 1'b0;
      flush_i         = 1'b0;
      repeat (4) @(posedge clk);
      #1 rst_n = 1'b1;

      wait_flushed();
      chk.check_val("is_flushed_o pulses", 32'(chk.flushes), 32'd1);
      chk.end_test("enable");

      run_random(80);
      chk.end_test("cache_rand");

      for (int i = 0; i < 40; i++)
         do_fetch({24'h000200, 1'b0, 3'(rand_bits(1)), 4'(rand_bits(2) << 2)});
      wait_idle();
      chk.end_test("cache_hits");

      fl_before = chk.flushes;
      flush_i   = 1'b1;
      wait_flushed();
      flush_i   = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      chk.check_val("is_flushed_o pulses", 32'(chk.flushes - fl_before), 32'd1);
      run_random(40);
      chk.end_test("flush");

      bypass_i = 1'b1;
      run_random(40);
      chk.end_test("bypass");

      fl_before = chk.flushes;
      bypass_i  = 1'b0;
      wait_flushed();
      repeat (3) @(posedge clk);
      #1;
      chk.check_val("is_flushed_o pulses", 32'(chk.flushes - fl_before), 32'd1);
      run_random(40);
      chk.end_test("reenable");

      chk.report_totals();
      if (chk.tot_errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

// File: tests/icache_checker.sv
/*
 * Testbench checker
 * Granted fetch queue, resident line model, refill protocol checks,
 * per-test result lines and totals
 */

`timescale 1ns/1ps

module icache_checker
(
   input logic         clk,
   input logic         rst_n,
   input logic         fetch_req_i,
   input logic [31:0]  fetch_addr_i,
   input logic         fetch_gnt_o,
   input logic         fetch_rvalid_o,
   input logic [31:0]  fetch_rdata_o,
   input logic         refill_req_o,
   input logic [31:0]  refill_addr_o,
   input logic         refill_gnt_i,
   input logic         refill_rvalid_i,
   input logic         bypass_i,
   input logic         is_bypassed_o,
   input logic         is_flushed_o
);
   `include "mem_model.svh"

   logic [31:0] q_addr    [$];   // Granted fetches, oldest first
   int          q_cyc     [$];
   logic        q_byp     [$];
   int          q_refills [$];

   bit          sure  [logic [27:0]];   // Lines that must still be cached
   bit          maybe [logic [27:0]];   // Lines that may be cached
   int          set_cnt [16];
   logic [27:0] drop_q [$];

   int          cyc = 0;
   int          outst = 0;
   logic        req_pend = 1'b0;
   logic [31:0] pend_addr;
   int          flushes = 0;
   int          checks = 0, errors = 0;
   int          tot_checks = 0, tot_errors = 0, tests = 0;

   logic [31:0] a;
   logic [27:0] line;
   logic        byp;
   int          gcyc, nref;

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic report_error(input string msg);
      checks++;
      errors++;
      $display("ERROR t=%0t %s", $time, msg);
   endtask

   function automatic int pending();
      return q_addr.size() + outst;
   endfunction

   task automatic end_test(input string name);
      $display("Test %-12s %0d checks, %0d errors", name, checks, errors);
      tests++;
      tot_checks += checks;
      tot_errors += errors;
      checks = 0;
      errors = 0;
   endtask

   task automatic report_totals();
      $display("Totals: %0d tests, %0d checks, %0d errors", tests, tot_checks, tot_errors);
   endtask

   // A refill into a full set evicts an unknown way
   task automatic add_line(input logic [27:0] ln);
      if (set_cnt[ln[3:0]] >= 4)
      begin
         drop_q = {};
         foreach (sure[k])
            if (k[3:0] == ln[3:0])
               drop_q.push_back(k);
         foreach (drop_q[i])
            sure.delete(drop_q[i]);
      end
      set_cnt[ln[3:0]]++;
      sure[ln]  = 1'b1;
      maybe[ln] = 1'b1;
   endtask

   always @(posedge clk)
   begin
      if (rst_n)
      begin
         cyc++;

         ////////////////////
         // Refill port
         if (req_pend)
         begin
            if (!refill_req_o)
               report_error("refill request dropped before its grant");
            else
               check_val("refill_addr_o", refill_addr_o, pend_addr);
         end
         req_pend  = refill_req_o && !refill_gnt_i;
         pend_addr = refill_addr_o;

         if (refill_rvalid_i)
         begin
            if (outst == 0)
               report_error("refill response without a granted request");
            else
               outst--;
         end

         if (refill_req_o && refill_gnt_i)
         begin
            if (outst != 0)
               report_error("second refill issued while one is outstanding");
            outst++;
            if (q_addr.size() == 0)
               report_error("refill issued with no fetch pending");
            else
            begin
               q_refills[0]++;
               if (q_byp[0])
                  check_val("refill_addr_o", refill_addr_o, q_addr[0]);
               else
                  check_val("refill_addr_o", refill_addr_o, {q_addr[0][31:4], 4'h0});
            end
         end

         ////////////////////
         // Fetch responses, in grant order
         if (fetch_rvalid_o)
         begin
            if (q_addr.size() == 0)
               report_error("fetch_rvalid_o with no granted request");
            else
            begin
               a    = q_addr.pop_front();
               gcyc = q_cyc.pop_front();
               byp  = q_byp.pop_front();
               nref = q_refills.pop_front();
               line = a[31:4];
               check_val("fetch_rdata_o", fetch_rdata_o, mem_word(a));
               if (nref > 1)
                  report_error("more than one refill for a single fetch");
               if (byp)
                  check_val("bypass refill count", 32'(nref), 32'd1);
               else
               begin
                  if (sure.exists(line))
                  begin
                     if (nref != 0)
                        report_error("refill issued for a resident line");
                     check_val("fetch_rvalid_o latency", 32'(cyc - gcyc), 32'd1);
                  end
                  else if (!maybe.exists(line) && nref == 0)
                     report_error("fetch of a line not resident returned without refill");
                  if (nref != 0)
                     add_line(line);
               end
            end
         end

         if (fetch_req_i && fetch_gnt_o)
         begin
            check_val("is_bypassed_o", 32'(is_bypassed_o), 32'(bypass_i));
            q_addr.push_back(fetch_addr_i);
            q_cyc.push_back(cyc);
            q_byp.push_back(bypass_i);
            q_refills.push_back(0);
         end

         if (is_flushed_o)
         begin
            flushes++;
            sure.delete();
            maybe.delete();
            foreach (set_cnt[s])
               set_cnt[s] = 0;
         end
      end
   end

endmodule

// File: verilog/icache_top.sv
/*
 * Instruction cache top level
 * Controller, tag and data arrays, victim selection
 */

`timescale 1ns/1ps

module icache_top
(
   input  logic                          clk,
   input  logic                          rst_n,

   // Processor fetch port
   input  logic                          fetch_req_i,
   input  logic [icache_pkg::ADDR_W-1:0] fetch_addr_i,
   output logic                          fetch_gnt_o,
   output logic                          fetch_rvalid_o,
   output logic [icache_pkg::WORD_W-1:0] fetch_rdata_o,

   // Refill port, single beat responses
   output logic                          refill_req_o,
   output logic [icache_pkg::ADDR_W-1:0] refill_addr_o,
   input  logic                          refill_gnt_i,
   input  logic                          refill_rvalid_i,
   input  icache_pkg::line_t             refill_rdata_i,

   input  logic                          bypass_i,
   input  logic                          flush_i,
   output logic                          is_bypassed_o,
   output logic                          is_flushed_o
);
   import icache_pkg::*;

   tag_port_if  tag_if ();
   data_port_if data_if ();

   way_vec_t victim_way;
   logic     victim_take;
   line_t    line_rdata;    // Hit way line from the data array

   icache_ctrl u_ctrl
   (
      .clk             (clk),
      .rst_n           (rst_n),
      .fetch_req_i     (fetch_req_i),
      .fetch_addr_i    (fetch_addr_i),
      .fetch_gnt_o     (fetch_gnt_o),
      .fetch_rvalid_o  (fetch_rvalid_o),
      .fetch_rdata_o   (fetch_rdata_o),
      .refill_req_o    (refill_req_o),
      .refill_addr_o   (refill_addr_o),
      .refill_gnt_i    (refill_gnt_i),
      .refill_rvalid_i (refill_rvalid_i),
      .refill_rdata_i  (refill_rdata_i),
      .bypass_i        (bypass_i),
      .flush_i         (flush_i),
      .is_bypassed_o   (is_bypassed_o),
      .is_flushed_o    (is_flushed_o),
      .tag_p           (tag_if.ctrl),
      .data_p          (data_if.ctrl),
      .victim_way_i    (victim_way),
      .victim_take_o   (victim_take),
      .line_rdata_i    (line_rdata)
   );

   icache_tag_array u_tag_array (.clk(clk), .rst_n(rst_n), .tag_p(tag_if.array));

   icache_data_array u_data_array
   (
      .clk          (clk),
      .data_p       (data_if.array),
      .hit_way_i    (tag_if.hit_way),
      .line_rdata_o (line_rdata)
   );

   icache_way_select u_way_select
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .valid_vec_i  (tag_if.valid_vec),
      .take_i       (victim_take),
      .victim_way_o (victim_way)
   );

endmodule

// File: verilog/icache_way_select.sv
/*
 * Victim way selection
 * First invalid way, else a way from an 8-bit LFSR
 */

`timescale 1ns/1ps

module icache_way_select
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  icache_pkg::way_vec_t valid_vec_i,
   input  logic                 take_i,
   output icache_pkg::way_vec_t victim_way_o
);
   import icache_pkg::*;

   logic [7:0] lfsr_q;
   logic       feedback;
   way_vec_t   free_way;
   way_vec_t   lfsr_way;

   // Taps 8,6,5,4 give the maximal sequence
   assign feedback = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         lfsr_q <= LFSR_SEED;
      else if (take_i)
         lfsr_q <= {lfsr_q[6:0], feedback};
   end

   // Lowest free way wins
   always_comb
   begin
      free_way = '0;
      for (int w = NB_WAYS-1; w >= 0; w--)
         if (!valid_vec_i[w])
            free_way = way_vec_t'(1) << w;
   end

   assign lfsr_way     = way_vec_t'(1) << lfsr_q[WAY_IDX_W-1:0];
   assign victim_way_o = (&valid_vec_i) ? lfsr_way : free_way;

endmodule

// File: verilog/icache_data_array.sv
/*
 * Data array
 * Line storage per way and set, refill write of one way,
 * registered read of all ways and hit way output select
 */

`timescale 1ns/1ps

module icache_data_array
(
   input  logic                             clk,
   data_port_if.array                       data_p,
   input  logic [icache_pkg::WAY_IDX_W-1:0] hit_way_i,
   output icache_pkg::line_t                line_rdata_o
);
   import icache_pkg::*;

   line_t mem  [NB_WAYS][NB_SETS];
   line_t rd_q [NB_WAYS];          // All ways of the read set

   always_ff @(posedge clk)
   begin
      if (data_p.wr_en)
      begin
         for (int w = 0; w < NB_WAYS; w++)
            if (data_p.wr_way[w])
               mem[w][data_p.wr_set] <= data_p.wr_line;
      end
   end

   // Read in parallel with the tag lookup
   always_ff @(posedge clk)
   begin
      if (data_p.rd_en)
      begin
         for (int w = 0; w < NB_WAYS; w++)
            rd_q[w] <= mem[w][data_p.rd_set];
      end
   end

   assign line_rdata_o = rd_q[hit_way_i];

endmodule

// File: verilog/icache_tag_array.sv
/*
 * Tag array
 * Valid bits and tags per way and set, registered read,
 * per-way compare, hit way index and valid vector
 */

`timescale 1ns/1ps

module icache_tag_array
(
   input  logic       clk,
   input  logic       rst_n,
   tag_port_if.array  tag_p
);
   import icache_pkg::*;

   tag_t     tags    [NB_WAYS][NB_SETS];
   way_vec_t valid_q [NB_SETS];
   set_idx_t set_q;       // Set of the last read
   tag_t     cmp_tag_q;   // Tag of the last read
   way_vec_t match;
   logic     invalidate;

   // Zero tag on all ways is the flush pattern
   assign invalidate = (&tag_p.wr_way) && (tag_p.wr_tag == '0);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int s = 0; s < NB_SETS; s++)
            valid_q[s] <= '0;
      end
      else if (tag_p.req && tag_p.we)
      begin
         for (int w = 0; w < NB_WAYS; w++)
            if (tag_p.wr_way[w])
               valid_q[tag_p.set][w] <= !invalidate;
      end
   end

   always_ff @(posedge clk)
   begin
      if (tag_p.req && tag_p.we)
      begin
         for (int w = 0; w < NB_WAYS; w++)
            if (tag_p.wr_way[w])
               tags[w][tag_p.set] <= tag_p.wr_tag;
      end
      else if (tag_p.req)
      begin
         set_q     <= tag_p.set;
         cmp_tag_q <= tag_p.wr_tag;
      end
   end

   ////////////////////
   // Compare
   for (genvar w = 0; w < NB_WAYS; w++)
   begin : g_cmp
      assign match[w] = valid_q[set_q][w] && (tags[w][set_q] == cmp_tag_q);
   end

   always_comb
   begin
      tag_p.hit_way = '0;
      for (int w = 0; w < NB_WAYS; w++)
         if (match[w])
            tag_p.hit_way = WAY_IDX_W'(w);
   end

   assign tag_p.hit       = |match;
   assign tag_p.valid_vec = valid_q[set_q];

endmodule

// File: verilog/icache_ctrl.sv
/*
 * Instruction cache controller
 * Fetch, lookup, miss refill, bypass and full flush FSM
 */

`timescale 1ns/1ps

module icache_ctrl
(
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          fetch_req_i,
   input  logic [icache_pkg::ADDR_W-1:0] fetch_addr_i,
   output logic                          fetch_gnt_o,
   output logic                          fetch_rvalid_o,
   output logic [icache_pkg::WORD_W-1:0] fetch_rdata_o,
   output logic                          refill_req_o,
   output logic [icache_pkg::ADDR_W-1:0] refill_addr_o,
   input  logic                          refill_gnt_i,
   input  logic                          refill_rvalid_i,
   input  icache_pkg::line_t             refill_rdata_i,
   input  logic                          bypass_i,
   input  logic                          flush_i,
   output logic                          is_bypassed_o,
   output logic                          is_flushed_o,
   tag_port_if.ctrl                      tag_p,
   data_port_if.ctrl                     data_p,
   input  icache_pkg::way_vec_t          victim_way_i,
   output logic                          victim_take_o,
   input  icache_pkg::line_t             line_rdata_i
);
   import icache_pkg::*;

   ctrl_state_e              state_q, state_d;
   logic [ADDR_W-1:0]        addr_q;       // Address of the fetch in flight
   way_vec_t                 way_q;        // Way picked for the refill
   set_idx_t                 flush_cnt_q;
   logic                     miss;
   logic [OFFS_LSB-3:0]      word_sel;

   assign miss     = (state_q == LOOKUP) && !tag_p.hit;
   assign word_sel = addr_q[OFFS_LSB-1:2];

   ////////////////////
   // State and counters
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q     <= DISABLED;
         flush_cnt_q <= '0;
      end
      else
      begin
         state_q <= state_d;
         if (state_q == FLUSH)
            flush_cnt_q <= flush_cnt_q + 1'b1;  // Wraps back to 0 on exit
      end
   end

   always_ff @(posedge clk)
   begin
      if (fetch_req_i && fetch_gnt_o)
         addr_q <= fetch_addr_i;
      if (miss)
         way_q <= victim_way_i;
   end

   ////////////////////
   // Next state and port control
   always_comb
   begin
      state_d        = state_q;
      fetch_gnt_o    = 1'b0;
      fetch_rvalid_o = 1'b0;
      refill_req_o   = 1'b0;
      refill_addr_o  = {addr_q[ADDR_W-1:OFFS_LSB], {OFFS_LSB{1'b0}}};
      is_bypassed_o  = 1'b0;
      is_flushed_o   = 1'b0;
      victim_take_o  = 1'b0;

      // Lookup reads use the incoming address
      tag_p.req      = 1'b0;
      tag_p.we       = 1'b0;
      tag_p.set      = fetch_addr_i[OFFS_LSB +: SET_W];
      tag_p.wr_way   = way_q;
      tag_p.wr_tag   = fetch_addr_i[OFFS_LSB+SET_W +: TAG_W];
      data_p.rd_en   = 1'b0;
      data_p.rd_set  = fetch_addr_i[OFFS_LSB +: SET_W];
      data_p.wr_en   = 1'b0;
      data_p.wr_way  = way_q;
      data_p.wr_set  = addr_q[OFFS_LSB +: SET_W];
      data_p.wr_line = refill_rdata_i;

      case (state_q)
         DISABLED:
         begin
            is_bypassed_o = 1'b1;
            if (bypass_i)
            begin
               fetch_gnt_o = fetch_req_i;     // Straight to the refill port
               if (fetch_req_i)
                  state_d = BYPASS_REFILL;
            end
            else
               state_d = FLUSH;               // Enabling the cache
         end

         BYPASS_REFILL:
         begin
            is_bypassed_o = 1'b1;
            refill_req_o  = 1'b1;
            refill_addr_o = addr_q;           // Unaligned fetch address
            if (refill_gnt_i)
               state_d = BYPASS_WAIT;
         end

         BYPASS_WAIT:
         begin
            is_bypassed_o  = 1'b1;
            fetch_rvalid_o = refill_rvalid_i;
            if (refill_rvalid_i)
               state_d = DISABLED;
         end

         FLUSH:
         begin
            tag_p.req    = 1'b1;
            tag_p.we     = 1'b1;
            tag_p.set    = flush_cnt_q;
            tag_p.wr_way = '1;
            tag_p.wr_tag = '0;
            if (flush_cnt_q == set_idx_t'(NB_SETS-1))
            begin
               is_flushed_o = 1'b1;
               state_d      = IDLE;
            end
         end

         IDLE:
         begin
            if (bypass_i)
               state_d = DISABLED;
            else if (flush_i)
               state_d = FLUSH;
            else
            begin
               fetch_gnt_o  = fetch_req_i;
               tag_p.req    = fetch_req_i;
               data_p.rd_en = fetch_req_i;
               if (fetch_req_i)
                  state_d = LOOKUP;
            end
         end

         LOOKUP:
         begin
            if (tag_p.hit)
            begin
               fetch_rvalid_o = 1'b1;
               // Back-to-back hits, unless a mode change is pending
               fetch_gnt_o    = fetch_req_i && !(bypass_i || flush_i);
               tag_p.req      = fetch_gnt_o;
               data_p.rd_en   = fetch_gnt_o;
               state_d        = fetch_gnt_o ? LOOKUP : IDLE;
            end
            else
            begin
               refill_req_o  = 1'b1;
               victim_take_o = &tag_p.valid_vec;  // Random victim used
               state_d       = refill_gnt_i ? WAIT_DONE : WAIT_GNT;
            end
         end

         WAIT_GNT:
         begin
            refill_req_o = 1'b1;
            if (refill_gnt_i)
               state_d = WAIT_DONE;
         end

         WAIT_DONE:
         begin
            fetch_rvalid_o = refill_rvalid_i;
            // Line and tag written with the response beat
            tag_p.req      = refill_rvalid_i;
            tag_p.we       = 1'b1;
            tag_p.set      = addr_q[OFFS_LSB +: SET_W];
            tag_p.wr_tag   = addr_q[OFFS_LSB+SET_W +: TAG_W];
            data_p.wr_en   = refill_rvalid_i;
            if (refill_rvalid_i)
               state_d = IDLE;
         end

         default: state_d = DISABLED;
      endcase
   end

   ////////////////////
   // Returned word
   always_comb
   begin
      case (state_q)
         LOOKUP:      fetch_rdata_o = line_rdata_i[word_sel];
         BYPASS_WAIT: fetch_rdata_o = refill_rdata_i[0];  // Refill port returns the word in lane 0
         default:     fetch_rdata_o = refill_rdata_i[word_sel];
      endcase
   end

endmodule

// File: verilog/icache_if.sv
/*
 * Internal cache ports
 * tag_port_if  : controller to tag array
 * data_port_if : controller to data array
 */

`timescale 1ns/1ps

interface tag_port_if;
   import icache_pkg::*;

   logic                 req;       // Read, or write when we is set
   logic                 we;
   set_idx_t             set;
   way_vec_t             wr_way;    // All ones with zero tag clears the set
   tag_t                 wr_tag;    // Also the compare tag of a read
   logic                 hit;
   logic [WAY_IDX_W-1:0] hit_way;
   way_vec_t             valid_vec;

   modport ctrl
   (
      output req, we, set, wr_way, wr_tag,
      input  hit, hit_way, valid_vec
   );

   modport array
   (
      input  req, we, set, wr_way, wr_tag,
      output hit, hit_way, valid_vec
   );
endinterface

interface data_port_if;
   import icache_pkg::*;

   logic     rd_en;
   set_idx_t rd_set;
   logic     wr_en;
   way_vec_t wr_way;   // One-hot
   set_idx_t wr_set;
   line_t    wr_line;

   modport ctrl  (output rd_en, rd_set, wr_en, wr_way, wr_set, wr_line);
   modport array (input  rd_en, rd_set, wr_en, wr_way, wr_set, wr_line);
endinterface

// File: verilog/icache_pkg.sv
/*
 * Instruction cache package
 * Cache geometry, address field widths, line and tag types, controller states
 */

package icache_pkg;

   ////////////////////
   // Geometry
   localparam int ADDR_W    = 32;                        // Fetch address width
   localparam int WORD_W    = 32;                        // Fetch data width
   localparam int LINE_W    = 128;                       // One refill beat per line
   localparam int NB_WAYS   = 4;
   localparam int WAY_IDX_W = $clog2(NB_WAYS);
   localparam int SET_W     = 4;                         // Set index is addr[7:4]
   localparam int NB_SETS   = 1 << SET_W;
   localparam int OFFS_LSB  = 4;                         // Byte offset inside a line
   localparam int TAG_W     = ADDR_W - SET_W - OFFS_LSB; // Tag is addr[31:8]

   // Replacement LFSR reset value, must not be zero
   localparam logic [7:0] LFSR_SEED = 8'hA5;

   ////////////////////
   // Types
   typedef logic [LINE_W/WORD_W-1:0][WORD_W-1:0] line_t;
   typedef logic [NB_WAYS-1:0]                   way_vec_t;
   typedef logic [SET_W-1:0]                     set_idx_t;
   typedef logic [TAG_W-1:0]                     tag_t;

   typedef enum logic [3:0]
   {
      DISABLED,       // Bypass mode, waiting for a fetch
      BYPASS_REFILL,  // Bypass fetch on the refill port
      BYPASS_WAIT,    // Bypass response pending
      FLUSH,          // Invalidate all sets
      IDLE,
      LOOKUP,         // Tag compare of the granted fetch
      WAIT_GNT,       // Miss refill waiting for grant
      WAIT_DONE       // Miss refill waiting for data
   } ctrl_state_e;

endpackage
